// ==== rtl/immu_pkg.sv ====
// Instruction MMU shared widths, entry layout and types
package immu_pkg;

   // Fetch address width
   localparam int unsigned immu_aw = 32;
   // Page offset bits, 4 KiB pages
   localparam int unsigned immu_page_bits = 12;
   // Virtual and physical page number width
   localparam int unsigned immu_vpn_w = immu_aw - immu_page_bits;
   // Width of one TLB bank word
   localparam int unsigned immu_dw = 32;

   // Set index bits, taken from the low end of the VPN
   localparam int unsigned itlb_idx_w = 4;
   // Entries per bank
   localparam int unsigned itlb_sets = 1 << itlb_idx_w;

   // Physical pages with the top bit clear are uncached when set
   localparam bit immu_unc_seg_en = 1'b1;

   // Low word layout
   // Valid flag
   localparam int unsigned ent_v_bit = 0;
   // Tag sits in the top bits of the low word
   localparam int unsigned ent_tag_lsb = immu_dw - immu_vpn_w;

   // High word layout
   // User-mode execute permission
   localparam int unsigned ent_ux_bit = 3;
   // Root-mode execute permission
   localparam int unsigned ent_rx_bit = 4;
   // Page is uncached
   localparam int unsigned ent_unc_bit = 7;
   // PPN sits in the top bits of the high word
   localparam int unsigned ent_ppn_lsb = immu_dw - immu_vpn_w;

   // VPN or PPN
   typedef logic [immu_vpn_w-1:0] page_num_t;
   // TLB set index
   typedef logic [itlb_idx_w-1:0] itlb_idx_t;
   // One bank entry
   typedef logic [immu_dw-1:0] tlb_word_t;

endpackage

// ==== rtl/itlb_bank.sv ====
// ITLB bank, 16 entries with one registered read port and one write port
`timescale 1ns/1ns

module itlb_bank
   import immu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Lookup port
   input  logic       re,
   input  itlb_idx_t  raddr,
   output tlb_word_t  rdata,
   // Maintenance write port
   input  logic       we,
   input  itlb_idx_t  waddr,
   input  tlb_word_t  wdata
);

   // Entry storage, contents undefined until software writes them
   tlb_word_t mem [itlb_sets];

   // Write port
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read
   // Same-edge write to the same index is not seen here, so read-first
   // Holds the last word while no lookup is strobed
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

   // Write index must be fully known whenever a write is strobed
   a_waddr_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      we |-> !$isunknown(waddr)
   )
   else $error("itlb_bank write with unknown index %h", waddr);

endmodule

// ==== rtl/itlb_resolve.sv ====
// ITLB resolver, latches the lookup and turns both bank words into PPN and exceptions
`timescale 1ns/1ns

module itlb_resolve
   import immu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Lookup request
   input  logic       re,
   input  page_num_t  vpn,
   input  logic       imme,
   input  logic       rm,
   // Registered bank words, aligned with the latches below
   input  tlb_word_t  tlb_l,
   input  tlb_word_t  tlb_h,
   // Translation result
   output page_num_t  ppn,
   output logic       eitm,
   output logic       eipf,
   output logic       uncached,
   output logic       rsp_valid
);

   // Latched lookup state
   page_num_t vpn_q;
   logic      imme_q;
   logic      rm_q;

   // Decoded entry fields
   logic      ent_v;
   page_num_t ent_tag;
   logic      ent_ux;
   logic      ent_rx;
   logic      ent_unc;
   page_num_t ent_ppn;

   // Raw lookup outcome before the response strobe
   logic      tlb_miss;
   logic      perm_denied;
   logic      exc_itm;
   logic      exc_ipf;
   logic      unc_page;
   logic      unc_seg;

   // Capture request on the same edge the banks read
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         vpn_q     <= '0;
         imme_q    <= 1'b0;
         rm_q      <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         // One-cycle response strobe per lookup
         rsp_valid <= re;
         if (re)
         begin
            vpn_q  <= vpn;
            imme_q <= imme;
            rm_q   <= rm;
         end
      end
   end

   // Low word fields
   assign ent_v   = tlb_l[ent_v_bit];
   assign ent_tag = tlb_l[ent_tag_lsb +: immu_vpn_w];

   // High word fields
   assign ent_ux  = tlb_h[ent_ux_bit];
   assign ent_rx  = tlb_h[ent_rx_bit];
   assign ent_unc = tlb_h[ent_unc_bit];
   assign ent_ppn = tlb_h[ent_ppn_lsb +: immu_vpn_w];

   // Invalid entry or tag mismatch
   assign tlb_miss = ~ent_v | (ent_tag != vpn_q);

   // Root mode needs rx, user mode needs ux
   assign perm_denied = (rm_q & ~ent_rx) | (~rm_q & ~ent_ux);

   // Exceptions only exist with translation on
   assign exc_itm = imme_q & tlb_miss;
   // Page fault only on a hit
   assign exc_ipf = imme_q & ~tlb_miss & perm_denied;

   // Identity mapping with translation off
   assign ppn = imme_q ? ent_ppn : vpn_q;

   // Uncached by page attribute, good hit only
   assign unc_page = imme_q & ~tlb_miss & ~perm_denied & ent_unc;

   // Fixed segment, physical pages below the top half
   assign unc_seg = immu_unc_seg_en & ~exc_itm & ~exc_ipf & ~ppn[immu_vpn_w-1];

   // Flags are only driven while a response is presented
   assign eitm     = rsp_valid & exc_itm;
   assign eipf     = rsp_valid & exc_ipf;
   assign uncached = rsp_valid & (unc_page | unc_seg);

   // Miss and page fault are mutually exclusive
   a_exc_mutex : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(eitm && eipf)
   )
   else $error("itlb_resolve eitm and eipf both set");

endmodule

// ==== rtl/immu.sv ====
// Instruction MMU top, two ITLB banks read in parallel feeding the resolver
`timescale 1ns/1ns

module immu
   import immu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Fetch lookup
   input  logic       re,
   input  page_num_t  vpn,
   // Privilege state
   input  logic       imme,
   input  logic       rm,
   // Low bank maintenance
   input  logic       tlbl_we,
   input  itlb_idx_t  tlbl_idx,
   input  tlb_word_t  tlbl_wdata,
   // High bank maintenance
   input  logic       tlbh_we,
   input  itlb_idx_t  tlbh_idx,
   input  tlb_word_t  tlbh_wdata,
   // Translation result
   output page_num_t  ppn,
   output logic       eitm,
   output logic       eipf,
   output logic       uncached,
   output logic       rsp_valid
);

   // Direct-mapped set select
   itlb_idx_t lkp_idx;
   // Registered bank words
   tlb_word_t tlb_l;
   tlb_word_t tlb_h;

   assign lkp_idx = vpn[itlb_idx_w-1:0];

   // Valid bit and tag
   itlb_bank u_tlb_l (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (lkp_idx),
      .rdata (tlb_l),
      .we    (tlbl_we),
      .waddr (tlbl_idx),
      .wdata (tlbl_wdata)
   );

   // Permissions, uncached bit and PPN
   itlb_bank u_tlb_h (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (lkp_idx),
      .rdata (tlb_h),
      .we    (tlbh_we),
      .waddr (tlbh_idx),
      .wdata (tlbh_wdata)
   );

   // Combines both words with the latched request
   itlb_resolve u_resolve (
      .clk       (clk),
      .rst_n     (rst_n),
      .re        (re),
      .vpn       (vpn),
      .imme      (imme),
      .rm        (rm),
      .tlb_l     (tlb_l),
      .tlb_h     (tlb_h),
      .ppn       (ppn),
      .eitm      (eitm),
      .eipf      (eipf),
      .uncached  (uncached),
      .rsp_valid (rsp_valid)
   );

endmodule

// ==== bench/immu_tb_table.svh ====
// Instruction MMU testbench table of TLB fills and lookups with expected results
`ifndef IMMU_TB_TABLE_SVH
`define IMMU_TB_TABLE_SVH

// add_write  op, index, low word, high word
// add_lookup vpn, imme, rm, ppn, eitm, eipf, uncached
task automatic load_table();
   // Idx 1 rx ux, idx 2 rx only, idx 3 ux and unc, idx 4 invalid
   add_write(op_wb, 4'h1, 32'h1234_1001, 32'h8000_1018);
   add_write(op_wb, 4'h2, 32'h0abc_2001, 32'h0004_2010);
   add_write(op_wb, 4'h3, 32'h5555_3001, 32'h9f00_3088);
   add_write(op_wb, 4'h4, 32'h7777_4000, 32'h0000_4018);
   // Idx 5 filled one bank at a time
   add_write(op_wl, 4'h5, 32'h3c3c_5001, 32'h0000_0000);
   add_write(op_wh, 4'h5, 32'h0000_0000, 32'h7fff_5098);
   // Translation off, identity mapping
   add_lookup(20'h77774, 1'b0, 1'b0, 20'h77774, 1'b0, 1'b0, 1'b1);
   add_lookup(20'hc0001, 1'b0, 1'b1, 20'hc0001, 1'b0, 1'b0, 1'b0);
   // Hits, back to back
   add_lookup(20'h12341, 1'b1, 1'b1, 20'h80001, 1'b0, 1'b0, 1'b0);
   add_lookup(20'h12341, 1'b1, 1'b0, 20'h80001, 1'b0, 1'b0, 1'b0);
   add_lookup(20'h0abc2, 1'b1, 1'b1, 20'h00042, 1'b0, 1'b0, 1'b1);
   add_lookup(20'h55553, 1'b1, 1'b0, 20'h9f003, 1'b0, 1'b0, 1'b1);
   add_lookup(20'h3c3c5, 1'b1, 1'b1, 20'h7fff5, 1'b0, 1'b0, 1'b1);
   // Invalid entry and tag mismatch
   add_lookup(20'h77774, 1'b1, 1'b1, 20'h00004, 1'b1, 1'b0, 1'b0);
   add_lookup(20'h12351, 1'b1, 1'b1, 20'h80001, 1'b1, 1'b0, 1'b0);
   // Execute bit missing for the mode
   add_lookup(20'h0abc2, 1'b1, 1'b0, 20'h00042, 1'b0, 1'b1, 1'b0);
   add_lookup(20'h55553, 1'b1, 1'b1, 20'h9f003, 1'b0, 1'b1, 1'b0);
   // Overwrite idx 1 high word, rx only and low PPN
   add_lookup(20'h12341, 1'b1, 1'b1, 20'h80001, 1'b0, 1'b0, 1'b0);
   add_write(op_wh, 4'h1, 32'h0000_0000, 32'h0010_1010);
   add_lookup(20'h12341, 1'b1, 1'b1, 20'h00101, 1'b0, 1'b0, 1'b1);
   add_lookup(20'h12341, 1'b1, 1'b0, 20'h00101, 1'b0, 1'b1, 1'b0);
   // Invalidate idx 2 through the low bank only
   add_write(op_wl, 4'h2, 32'h0abc_2000, 32'h0000_0000);
   add_lookup(20'h0abc2, 1'b1, 1'b1, 20'h00042, 1'b1, 1'b0, 1'b0);
   // Isolated lookup after a gap
   add_idle();
   add_lookup(20'h55553, 1'b1, 1'b0, 20'h9f003, 1'b0, 1'b0, 1'b1);
   add_idle();
endtask

`endif

// ==== bench/immu_tb.sv ====
// Instruction MMU testbench, table-driven lookups and TLB fills with random identity lookups
`timescale 1ns/1ns

module immu_tb
   import immu_pkg::*;
();

   localparam int unsigned clk_period = 20;
   localparam int unsigned rst_cycles = 4;
   // Extra translation-off lookups
   localparam int unsigned n_rand = 16;

   // Row kinds
   localparam logic [2:0] op_idle = 3'd0;
   localparam logic [2:0] op_wl   = 3'd1;
   localparam logic [2:0] op_wh   = 3'd2;
   localparam logic [2:0] op_wb   = 3'd3;
   localparam logic [2:0] op_lk   = 3'd4;

   typedef struct packed {
      logic [2:0] op;
      itlb_idx_t  idx;
      tlb_word_t  wl;
      tlb_word_t  wh;
      page_num_t  vpn;
      logic       imme;
      logic       rm;
      page_num_t  exp_ppn;
      logic       exp_eitm;
      logic       exp_eipf;
      logic       exp_unc;
   } row_t;

   logic clk = 1'b0;
   logic rst_n;
   logic re;
   page_num_t vpn;
   logic imme;
   logic rm;
   logic tlbl_we;
   itlb_idx_t tlbl_idx;
   tlb_word_t tlbl_wdata;
   logic tlbh_we;
   itlb_idx_t tlbh_idx;
   tlb_word_t tlbh_wdata;
   page_num_t ppn;
   logic eitm;
   logic eipf;
   logic uncached;
   logic rsp_valid;

   row_t tbl[$];
   row_t prev;
   row_t idle_row;
   logic [31:0] rnd_state = 32'hc42a_1731;
   bit tbl_ready = 1'b0;

   always #(clk_period / 2) clk = ~clk;

   immu UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .re         (re),
      .vpn        (vpn),
      .imme       (imme),
      .rm         (rm),
      .tlbl_we    (tlbl_we),
      .tlbl_idx   (tlbl_idx),
      .tlbl_wdata (tlbl_wdata),
      .tlbh_we    (tlbh_we),
      .tlbh_idx   (tlbh_idx),
      .tlbh_wdata (tlbh_wdata),
      .ppn        (ppn),
      .eitm       (eitm),
      .eipf       (eipf),
      .uncached   (uncached),
      .rsp_valid  (rsp_valid)
   );

   // 32-bit xorshift step
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Stops the run at the first mismatch
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic add_write(input logic [2:0] op, input itlb_idx_t idx,
                            input tlb_word_t wl, input tlb_word_t wh);
      row_t r;
      r = '0;
      r.op = op;
      r.idx = idx;
      r.wl = wl;
      r.wh = wh;
      tbl.push_back(r);
   endtask

   task automatic add_lookup(input page_num_t v, input logic im, input logic m,
                             input page_num_t p, input logic e_tm, input logic e_pf,
                             input logic unc);
      row_t r;
      r = '0;
      r.op = op_lk;
      r.vpn = v;
      r.imme = im;
      r.rm = m;
      r.exp_ppn = p;
      r.exp_eitm = e_tm;
      r.exp_eipf = e_pf;
      r.exp_unc = unc;
      tbl.push_back(r);
   endtask

   task automatic add_idle();
      tbl.push_back(idle_row);
   endtask

   `include "immu_tb_table.svh"

   // Translation off, so PPN is the VPN and only the segment rule applies
   task automatic add_random_rows();
      page_num_t v;
      for (int k = 0; k < n_rand; k++)
      begin
         rnd_state = xorshift32(rnd_state);
         // Alternate the top bit so both segment halves are covered
         v = {k[0], rnd_state[immu_vpn_w-2:0]};
         add_lookup(v, 1'b0, rnd_state[31], v, 1'b0, 1'b0, immu_unc_seg_en & ~v[immu_vpn_w-1]);
      end
   endtask

   task automatic apply_row(input row_t r);
      re         <= (r.op == op_lk);
      vpn        <= r.vpn;
      imme       <= r.imme;
      rm         <= r.rm;
      tlbl_we    <= (r.op == op_wl) || (r.op == op_wb);
      tlbl_idx   <= r.idx;
      tlbl_wdata <= r.wl;
      tlbh_we    <= (r.op == op_wh) || (r.op == op_wb);
      tlbh_idx   <= r.idx;
      tlbh_wdata <= r.wh;
   endtask

   // Response to the row sampled at the last rising edge
   task automatic check_response(input row_t r);
      if (r.op == op_lk)
      begin
         check_value("rsp_valid", 32'(rsp_valid), 32'd1);
         check_value("ppn", 32'(ppn), 32'(r.exp_ppn));
         check_value("eitm", 32'(eitm), 32'(r.exp_eitm));
         check_value("eipf", 32'(eipf), 32'(r.exp_eipf));
         check_value("uncached", 32'(uncached), 32'(r.exp_unc));
      end
      else
      begin
         // No lookup, so no strobe and all flags low
         check_value("rsp_valid", 32'(rsp_valid), 32'd0);
         check_value("eitm", 32'(eitm), 32'd0);
         check_value("eipf", 32'(eipf), 32'd0);
         check_value("uncached", 32'(uncached), 32'd0);
      end
   endtask

   initial
   begin
      idle_row = '0;
      idle_row.op = op_idle;
      rst_n <= 1'b0;
      apply_row(idle_row);
      load_table();
      add_random_rows();
      tbl_ready = 1'b1;
      repeat (rst_cycles) @(posedge clk);
      rst_n <= 1'b1;
      // Before any lookup the previous row counts as idle
      prev = idle_row;
      for (int i = 0; i < tbl.size(); i++)
      begin
         @(posedge clk);
         apply_row(tbl[i]);
         @(negedge clk);
         check_response(prev);
         prev = tbl[i];
      end
      // Drain the last response, then one quiet cycle
      @(posedge clk);
      apply_row(idle_row);
      @(negedge clk);
      check_response(prev);
      @(negedge clk);
      check_response(idle_row);
      $display("Simulation finished: PASS");
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial
   begin
      int unsigned limit;
      wait (tbl_ready);
      limit = tbl.size() * 2 * clk_period + (rst_cycles + 2) * clk_period;
      #(limit);
      $display("Watchdog expired before all table rows were applied");
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
   end

endmodule

// ==== build.f ====
+incdir+bench
rtl/immu_pkg.sv
rtl/itlb_bank.sv
rtl/itlb_resolve.sv
rtl/immu.sv
bench/immu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles and runs the instruction MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/1ns \
   -f build.f \
   --top-module immu_tb \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vimmu_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit $status
fi

exit 0
